/* hdl/dz_pkg.sv */
package dz_pkg;

    // picture number from the panel switches
    typedef logic [3:0] glyph_idx_t;

    // scanned row, 0 is the top row
    typedef logic [2:0] row_idx_t;

    // one row of LEDs, bit 7 is the leftmost column
    typedef logic [7:0] row_bits_t;

    // clocks per scanned row, small for simulation
    localparam int SCAN_DIV = 8;

    localparam int SCAN_CNT_W = $clog2(SCAN_DIV);

    localparam int NUM_ROWS = 8;

    // the two red-only pictures
    localparam glyph_idx_t GLYPH_HEART  = 4'd8;
    localparam glyph_idx_t GLYPH_THERMO = 4'd11;

endpackage

/* hdl/input_sync.sv */
`timescale 1ns/10ps

module input_sync (
    input  logic               clk,
    input  logic               rst,
    input  logic               temp,
    input  logic               st,
    input  dz_pkg::glyph_idx_t num,
    output logic               temp_s,
    output logic               st_s,
    output dz_pkg::glyph_idx_t glyph
);

    import dz_pkg::*;

    logic       temp_meta;
    logic       st_meta;
    glyph_idx_t num_meta;

    // two flops per bit, the switches are asynchronous to clk
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            temp_meta <= 1'b0;
            st_meta   <= 1'b0;
            num_meta  <= '0;
            temp_s    <= 1'b0;
            st_s      <= 1'b0;
            glyph     <= '0;
        end
        else
        begin
            temp_meta <= temp;
            st_meta   <= st;
            num_meta  <= num;  // bus may skew for one clock
            temp_s    <= temp_meta;
            st_s      <= st_meta;
            glyph     <= num_meta;
        end
    end

endmodule

/* hdl/row_scanner.sv */
`timescale 1ns/10ps

module row_scanner (
    input  logic             clk,
    input  logic             rst,
    input  logic             enable,
    output dz_pkg::row_idx_t row_idx
);

    import dz_pkg::*;

    logic [SCAN_CNT_W-1:0] div_cnt;
    logic                  div_wrap;

    assign div_wrap = (div_cnt == SCAN_CNT_W'(SCAN_DIV - 1));

    // clock divider, one tick per row period
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            div_cnt <= '0;
        else if (!enable)
            div_cnt <= '0;
        else if (div_wrap)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // row counter
    // held at 0 while disabled so a new frame starts at the top
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row_idx <= '0;
        else if (!enable)
            row_idx <= '0;
        else if (div_wrap)
        begin
            if (row_idx == row_idx_t'(NUM_ROWS - 1))
                row_idx <= '0;
            else
                row_idx <= row_idx + row_idx_t'(1);
        end
    end

endmodule

/* hdl/glyph_rom.sv */
`timescale 1ns/10ps

module glyph_rom (
    input  logic               temp,
    input  dz_pkg::glyph_idx_t glyph,
    input  dz_pkg::row_idx_t   row_idx,
    output dz_pkg::row_bits_t  green,
    output dz_pkg::row_bits_t  red
);

    import dz_pkg::*;

    row_bits_t heart_row;
    row_bits_t thermo_row;

    // green plane
    always_comb
    begin
        green = '0;
        case (glyph)
            4'd0:  // smallest blob
            begin
                case (row_idx)
                    3'd2, 3'd5: green = 8'b0001_1000;
                    3'd3, 3'd4: green = 8'b0011_1100;
                    default:    green = '0;
                endcase
            end
            4'd1:
            begin
                case (row_idx)
                    3'd2, 3'd5: green = 8'b0011_1000;
                    3'd3, 3'd4: green = 8'b0111_1100;
                    default:    green = '0;
                endcase
            end
            4'd2:
            begin
                case (row_idx)
                    3'd2, 3'd5: green = 8'b0011_1100;
                    3'd3, 3'd4: green = 8'b0111_1110;
                    default:    green = '0;
                endcase
            end
            4'd3:
            begin
                case (row_idx)
                    3'd1, 3'd6:             green = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5: green = 8'b0111_1110;
                    default:                green = '0;
                endcase
            end
            4'd4:  // largest blob, touches top and bottom
            begin
                case (row_idx)
                    3'd0, 3'd7: green = 8'b0011_1100;
                    3'd1, 3'd6: green = 8'b0111_1110;
                    default:    green = 8'b1111_1111;
                endcase
            end
            4'd5:
                green = 8'b1111_1111;  // full panel
            4'd6:  // landscape
            begin
                case (row_idx)
                    3'd0:    green = 8'b1100_0011;
                    3'd1:    green = 8'b1110_0011;
                    3'd2:    green = 8'b1111_0001;
                    3'd3:    green = 8'b1110_0011;
                    3'd4:    green = 8'b1100_0111;
                    3'd5:    green = 8'b1110_0111;
                    3'd6:    green = 8'b1111_0111;
                    default: green = 8'b1111_1011;
                endcase
            end
            4'd7:  // second landscape
            begin
                case (row_idx)
                    3'd1:    green = 8'b0000_0001;
                    3'd2:    green = 8'b1000_0001;
                    3'd3:    green = 8'b1100_0011;
                    3'd4:    green = 8'b1000_0011;
                    3'd5:    green = 8'b1100_0111;
                    3'd6:    green = 8'b1110_0111;
                    3'd7:    green = 8'b1111_0011;
                    default: green = '0;
                endcase
            end
            4'd9:
            begin
                case (row_idx)
                    3'd2:    green = 8'b0110_0000;
                    3'd3:    green = 8'b1111_1100;
                    3'd4:    green = 8'b0011_1111;
                    3'd5:    green = 8'b0011_1110;
                    3'd6:    green = 8'b0001_1100;
                    default: green = '0;
                endcase
            end
            4'd10:  // flame
            begin
                case (row_idx)
                    3'd2:       green = 8'b0001_1000;
                    3'd3:       green = 8'b0011_1100;
                    3'd4, 3'd5: green = 8'b0111_1110;
                    3'd6:       green = 8'b0010_0100;
                    default:    green = '0;
                endcase
            end
            default:
                green = '0;
        endcase
    end

    always_comb
    begin
        case (row_idx)
            3'd1:    heart_row = 8'b0011_1000;
            3'd2:    heart_row = 8'b0100_0100;
            3'd3:    heart_row = 8'b0101_1010;
            3'd4:    heart_row = 8'b0100_1010;
            3'd5:    heart_row = 8'b0011_0010;
            3'd6:    heart_row = 8'b1100_0100;
            3'd7:    heart_row = 8'b0011_1000;
            default: heart_row = '0;
        endcase
    end

    always_comb
    begin
        case (row_idx)
            3'd0:    thermo_row = 8'b1110_0000;
            3'd1:    thermo_row = 8'b0110_0000;
            3'd2:    thermo_row = 8'b1110_0000;
            3'd3:    thermo_row = 8'b0011_0000;
            3'd4:    thermo_row = 8'b0011_0001;
            3'd5:    thermo_row = 8'b0011_0011;
            3'd6:    thermo_row = 8'b0011_1110;
            default: thermo_row = 8'b0001_1100;
        endcase
    end

    // red plane and colour rule
    // blobs and full panel only turn amber when temp is high
    always_comb
    begin
        case (glyph)
            GLYPH_HEART:
                red = heart_row;
            GLYPH_THERMO:
                red = thermo_row;
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5:
                red = temp ? green : '0;
            4'd6, 4'd7, 4'd9:
                red = green;  // always amber
            default:
                red = '0;
        endcase
    end

endmodule

/* hdl/matrix_driver.sv */
`timescale 1ns/10ps

module matrix_driver (
    input  logic              clk,
    input  logic              rst,
    input  logic              enable,
    input  dz_pkg::row_idx_t  row_idx,
    input  dz_pkg::row_bits_t green,
    input  dz_pkg::row_bits_t red,
    output dz_pkg::row_bits_t row,
    output dz_pkg::row_bits_t colg,
    output dz_pkg::row_bits_t colr
);

    import dz_pkg::*;

    row_bits_t row_sel;

    // one-hot, active low
    always_comb
    begin
        row_sel = '1;
        for (int i = 0; i < NUM_ROWS; i++)
        begin
            if (row_idx == row_idx_t'(i))
                row_sel[i] = 1'b0;
        end
    end

    // rows and columns change on the same edge
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= '1;
            colg <= '0;
            colr <= '0;
        end
        else if (!enable)
        begin
            row  <= '1;  // blank panel
            colg <= '0;
            colr <= '0;
        end
        else
        begin
            row  <= row_sel;
            colg <= green;
            colr <= red;
        end
    end

endmodule

/* hdl/dz_display.sv */
`timescale 1ns/10ps

module dz_display (
    input  logic               clk,
    input  logic               rst,
    input  logic               temp,
    input  logic               st,
    input  dz_pkg::glyph_idx_t num,
    output dz_pkg::row_bits_t  row,
    output dz_pkg::row_bits_t  colr,
    output dz_pkg::row_bits_t  colg
);

    import dz_pkg::*;

    logic       temp_s;
    logic       st_s;
    glyph_idx_t glyph;
    row_idx_t   row_idx;
    row_bits_t  green;
    row_bits_t  red;

    input_sync u_input_sync (
        .clk    (clk),
        .rst    (rst),
        .temp   (temp),
        .st     (st),
        .num    (num),
        .temp_s (temp_s),
        .st_s   (st_s),
        .glyph  (glyph)
    );

    row_scanner u_row_scanner (
        .clk     (clk),
        .rst     (rst),
        .enable  (st_s),
        .row_idx (row_idx)
    );

    // patterns for the row being scanned
    glyph_rom u_glyph_rom (
        .temp    (temp_s),
        .glyph   (glyph),
        .row_idx (row_idx),
        .green   (green),
        .red     (red)
    );

    matrix_driver u_matrix_driver (
        .clk     (clk),
        .rst     (rst),
        .enable  (st_s),
        .row_idx (row_idx),
        .green   (green),
        .red     (red),
        .row     (row),
        .colg    (colg),
        .colr    (colr)
    );

endmodule

/* tests/dz_glyph_table.svh */
`ifndef DZ_GLYPH_TABLE_SVH
`define DZ_GLYPH_TABLE_SVH

// green plane of pictures 0 to 15
// one 64-bit word per picture, the high byte is row 0
localparam logic [63:0] GREEN_FRAMES [16] = '{
    64'h0000_183C_3C18_0000,  // 0 smallest blob
    64'h0000_387C_7C38_0000,
    64'h0000_3C7E_7E3C_0000,
    64'h003C_7E7E_7E7E_3C00,
    64'h3C7E_FFFF_FFFF_7E3C,  // 4 largest blob
    64'hFFFF_FFFF_FFFF_FFFF,  // full panel
    64'hC3E3_F1E3_C7E7_F7FB,  // landscape
    64'h0001_81C3_83C7_E7F3,
    64'h0000_0000_0000_0000,  // heart, red only
    64'h0000_60FC_3F3E_1C00,
    64'h0000_183C_7E7E_2400,  // flame, green only
    64'h0000_0000_0000_0000,  // thermometer, red only
    64'h0000_0000_0000_0000,
    64'h0000_0000_0000_0000,
    64'h0000_0000_0000_0000,
    64'h0000_0000_0000_0000
};

localparam logic [63:0] HEART_FRAME  = 64'h0038_445A_4A32_C438;
localparam logic [63:0] THERMO_FRAME = 64'hE060_E030_3133_3E1C;

function automatic row_bits_t frame_row(logic [63:0] frame, int r);
    return frame[63 - 8*r -: 8];
endfunction

function automatic row_bits_t expect_green(glyph_idx_t g, int r);
    return frame_row(GREEN_FRAMES[g], r);
endfunction

// red follows green for 6, 7 and 9, for 0 to 5 only when hot
function automatic row_bits_t expect_red(glyph_idx_t g, int r, logic hot);
    row_bits_t bits;
    bits = '0;
    if (g == GLYPH_HEART)
        bits = frame_row(HEART_FRAME, r);
    else if (g == GLYPH_THERMO)
        bits = frame_row(THERMO_FRAME, r);
    else if (g == 4'd6 || g == 4'd7 || g == 4'd9)
        bits = expect_green(g, r);
    else if (g <= 4'd5 && hot)
        bits = expect_green(g, r);
    return bits;
endfunction

`endif

/* tests/tb_dz_display.sv */
`timescale 1ns/10ps

module tb_dz_display;

    import dz_pkg::*;

    `include "dz_glyph_table.svh"

    localparam int NUM_ENTRIES = 34;

    logic       clk = 1'b0;
    logic       rst;
    logic       temp;
    logic       st;
    glyph_idx_t num;
    row_bits_t  row;
    row_bits_t  colr;
    row_bits_t  colg;

    // stimulus and expected frames per entry
    glyph_idx_t  tab_num   [NUM_ENTRIES];
    logic        tab_temp  [NUM_ENTRIES];
    logic        tab_st    [NUM_ENTRIES];
    logic [63:0] tab_green [NUM_ENTRIES];
    logic [63:0] tab_red   [NUM_ENTRIES];
    int          order     [NUM_ENTRIES];

    int          n_checks;
    int          n_errors;
    int          n_timeouts;
    row_bits_t   last_row;

    dz_display dut0 (
        .clk  (clk),
        .rst  (rst),
        .temp (temp),
        .st   (st),
        .num  (num),
        .row  (row),
        .colr (colr),
        .colg (colg)
    );

    always #4 clk = ~clk;

    task automatic check_value(string name, row_bits_t got, row_bits_t exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // sample at the falling edge
    // first lit row after blanking must be row 0
    task automatic step_clock();
        @(negedge clk);
        if (last_row == 8'hFF && row != 8'hFF)
            check_value("row after enable", row, 8'hFE);
        last_row = row;
    endtask

    task automatic build_table();
        for (int i = 0; i < NUM_ENTRIES; i++)
        begin
            tab_num[i]  = glyph_idx_t'(i % 16);
            tab_temp[i] = (i < 16);
            tab_st[i]   = (i < 32);
            if (i == 32)
                tab_num[i] = 4'd5;  // blanking of a full panel
            else if (i == 33)
                tab_num[i] = GLYPH_HEART;
            tab_green[i] = '0;
            tab_red[i]   = '0;
            if (tab_st[i])
            begin
                for (int r = 0; r < NUM_ROWS; r++)
                begin
                    tab_green[i][63 - 8*r -: 8] = expect_green(tab_num[i], r);
                    tab_red[i][63 - 8*r -: 8]   = expect_red(tab_num[i], r, tab_temp[i]);
                end
            end
            order[i] = i;
        end
    endtask

    // first falling edge of a new row 0
    task automatic wait_scan_start(output bit found);
        row_bits_t prev;
        int        n;
        found = 1'b0;
        n = 0;
        while (!found && n < 10 * SCAN_DIV)
        begin
            prev = last_row;
            step_clock();
            if (row == 8'hFE && prev != 8'hFE)
                found = 1'b1;
            n++;
        end
    endtask

    task automatic check_frame(int idx);
        bit found;
        wait_scan_start(found);
        if (!found)
        begin
            n_timeouts++;
            $display("timeout: no row scan seen for entry %0d, picture %0d", idx, tab_num[idx]);
        end
        else
        begin
            for (int r = 0; r < NUM_ROWS; r++)
            begin
                for (int c = 0; c < SCAN_DIV; c++)
                begin
                    if (r != 0 || c != 0)
                        step_clock();
                    check_value("row", row, ~(8'b1 << r));  // held SCAN_DIV clocks
                    if (c == SCAN_DIV / 2)
                    begin
                        check_value($sformatf("colg row %0d", r), colg,
                                    frame_row(tab_green[idx], r));
                        check_value($sformatf("colr row %0d", r), colr,
                                    frame_row(tab_red[idx], r));
                    end
                end
            end
            step_clock();
            check_value("row wrap", row, 8'hFE);
        end
    endtask

    task automatic check_blank_frame();
        repeat (NUM_ROWS * SCAN_DIV)
        begin
            step_clock();
            check_value("row blank", row, 8'hFF);
            check_value("colg blank", colg, 8'h00);
            check_value("colr blank", colr, 8'h00);
        end
    endtask

    task automatic apply_entry(int idx);
        @(posedge clk);
        num  <= tab_num[idx];
        temp <= tab_temp[idx];
        st   <= tab_st[idx];
        repeat (6) step_clock();
        if (tab_st[idx])
            check_frame(idx);
        else
            check_blank_frame();
    endtask

    initial
    begin
        int i;
        int j;
        int tmp;
        rst  <= 1'b1;
        temp <= 1'b0;
        st   <= 1'b0;
        num  <= '0;
        n_checks   = 0;
        n_errors   = 0;
        n_timeouts = 0;
        last_row   = 8'hFF;
        void'($urandom(11));
        build_table();

        repeat (3) step_clock();
        check_value("row in reset", row, 8'hFF);
        check_value("colg in reset", colg, 8'h00);
        check_value("colr in reset", colr, 8'h00);
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (4) step_clock();
        check_value("row after reset", row, 8'hFF);
        check_value("colg after reset", colg, 8'h00);
        check_value("colr after reset", colr, 8'h00);

        for (i = 0; i < NUM_ENTRIES; i++)
            apply_entry(i);

        // second pass in shuffled order
        for (i = NUM_ENTRIES - 1; i > 0; i--)
        begin
            j = int'($urandom % (i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (i = 0; i < NUM_ENTRIES; i++)
            apply_entry(order[i]);

        $display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
        if (n_errors == 0 && n_timeouts == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

/* dz_display.f */
+incdir+tests
hdl/dz_pkg.sv
hdl/input_sync.sv
hdl/row_scanner.sv
hdl/glyph_rom.sv
hdl/matrix_driver.sv
hdl/dz_display.sv
tests/tb_dz_display.sv

/* run_sim.sh */
#!/bin/sh
# build and run the dot matrix testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module tb_dz_display \
    -f dz_display.f \
    --Mdir obj_dir \
    -o sim_dz_display

./obj_dir/sim_dz_display > sim.log 2>&1
cat sim.log

if grep -qx "all tests passed" sim.log; then
    echo "simulation PASS"
else
    echo "simulation FAIL"
    exit 1
fi
